// File: hdl/denseLayer.sv
`default_nettype none

module denseLayer (
	input wire clk,
	input wire reset,
	input wire nnTypesPkg::activationT heldWords [nnWeightsPkg::numInputs],
	input wire frameValid,
	output nnTypesPkg::neuronOutT outputs [nnWeightsPkg::numNeurons],
	output nnTypesPkg::classIdxT bestClass,
	output logic resultValid
);
	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	neuronOutT neuronOuts [numNeurons];
	neuronOutT bestValue;
	classIdxT bestIndex;
	logic [neuronLatency-1:0] validDelay;

	for (genvar n = 0; n < numNeurons; n++)
	begin : neuronGen
		denseNeuron #(
			.neuronIndex(n)
		) neuron (
			.clk(clk),
			.reset(reset),
			.inWords(heldWords),
			.activation(neuronOuts[n])
		);
	end

	// one stage per neuron register, so the top bit is high while the ReLU outputs are fresh.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validDelay <= '0;
		end
		else
		begin
			validDelay <= {validDelay[neuronLatency-2:0], frameValid};
		end
	end

	// strict compare, so on a tie the lowest index is kept.
	always_comb
	begin
		bestValue = neuronOuts[0];
		bestIndex = '0;
		for (int i = 1; i < numNeurons; i++)
		begin
			if (neuronOuts[i] > bestValue)
			begin
				bestValue = neuronOuts[i];
				bestIndex = classIdxT'(i);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < numNeurons; i++)
			begin
				outputs[i] <= '0;
			end
			bestClass <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= validDelay[neuronLatency-1];
			if (validDelay[neuronLatency-1])
			begin
				for (int i = 0; i < numNeurons; i++)
				begin
					outputs[i] <= neuronOuts[i];
				end
				bestClass <= bestIndex;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/denseNeuron.sv
`default_nettype none

module denseNeuron #(
	parameter int neuronIndex = 0
) (
	input wire clk,
	input wire reset,
	input wire nnTypesPkg::activationT inWords [nnWeightsPkg::numInputs],
	output nnTypesPkg::neuronOutT activation
);
	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	activationT inReg [numInputs];
	accumT products [numInputs];
	accumT sumNext;
	accumT sumReg;

	// the input stage samples every cycle.
	// The held frame is stable, so the registered copy is valid one edge after frameValid.
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < numInputs; i++)
		begin
			inReg[i] <= inWords[i];
		end
	end

	// only the low 32 bits of each product are kept, so the sum wraps modulo 2^32.
	always_comb
	begin
		for (int i = 0; i < numInputs; i++)
		begin
			products[i] = inReg[i] * weightTable[neuronIndex][i];
		end
	end

	always_comb
	begin
		sumNext = biasTable[neuronIndex];
		for (int i = 0; i < numInputs; i++)
		begin
			sumNext = sumNext + products[i];
		end
	end

	always_ff @(posedge clk)
	begin
		sumReg <= sumNext;
	end

	// ReLU on the two's complement sum, then keep bits 28 down to 13.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
		end
		else if (sumReg[wordWidth-1])
		begin
			activation <= '0;
		end
		else
		begin
			activation <= sumReg[fracBits +: neuronOutWidth];
		end
	end

endmodule

`default_nettype wire

// File: hdl/frameBuffer.sv
`default_nettype none

module frameBuffer (
	input wire clk,
	input wire reset,
	input wire nnTypesPkg::activationT frameWords [nnWeightsPkg::numInputs],
	input wire frameDone,
	output nnTypesPkg::activationT heldWords [nnWeightsPkg::numInputs],
	output logic frameValid
);
	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	// the copy lets the loader start refilling while the layer still reads this frame.
	always_ff @(posedge clk)
	begin
		if (frameDone)
		begin
			for (int i = 0; i < numInputs; i++)
			begin
				heldWords[i] <= frameWords[i];
			end
		end
	end

	// valid rises together with the new copy.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			frameValid <= 1'b0;
		end
		else
		begin
			frameValid <= frameDone;
		end
	end

endmodule

`default_nettype wire

// File: hdl/nnInferenceTop.sv
`default_nettype none

module nnInferenceTop (
	input wire clk,
	input wire reset,
	input wire sampleStrobe,
	input wire nnTypesPkg::activationT sampleData,
	output nnTypesPkg::neuronOutT outputs [nnWeightsPkg::numNeurons],
	output nnTypesPkg::classIdxT bestClass,
	output logic resultValid
);
	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	activationT frameWords [numInputs];
	activationT heldWords [numInputs];
	logic frameDone;
	logic frameValid;

	sampleLoader loader (
		.clk(clk),
		.reset(reset),
		.sampleStrobe(sampleStrobe),
		.sampleData(sampleData),
		.frameWords(frameWords),
		.frameDone(frameDone)
	);

	// the buffer decouples loading from the layer, so frames may overlap.
	frameBuffer buffer (
		.clk(clk),
		.reset(reset),
		.frameWords(frameWords),
		.frameDone(frameDone),
		.heldWords(heldWords),
		.frameValid(frameValid)
	);

	denseLayer layer (
		.clk(clk),
		.reset(reset),
		.heldWords(heldWords),
		.frameValid(frameValid),
		.outputs(outputs),
		.bestClass(bestClass),
		.resultValid(resultValid)
	);

endmodule

`default_nettype wire

// File: hdl/nnTypesPkg.sv
`default_nettype none

package nnTypesPkg;

	localparam int wordWidth = 32;
	localparam int neuronOutWidth = 16;
	localparam int classIdxWidth = 2;

	// the datapath treats every word as a plain bit vector.
	// Products and sums wrap at the word width, and the sign is read only from bit 31 of the sum.
	typedef logic [wordWidth-1:0] activationT;

	typedef logic [wordWidth-1:0] weightT;

	typedef logic [wordWidth-1:0] accumT;

	// one ReLU result, a 16-bit slice of the accumulator.
	typedef logic [neuronOutWidth-1:0] neuronOutT;

	// index of one neuron in the layer.
	typedef logic [classIdxWidth-1:0] classIdxT;

endpackage

`default_nettype wire

// File: hdl/nnWeightsPkg.sv
`default_nettype none

package nnWeightsPkg;

	localparam int numInputs = 15;
	localparam int numNeurons = 4;

	// the ReLU output is the accumulator scaled by 2^-fracBits.
	localparam int fracBits = 13;

	// input stage, sum stage and ReLU stage.
	localparam int neuronLatency = 3;

	localparam int countWidth = $clog2(numInputs);
	localparam logic [countWidth-1:0] lastWord = countWidth'(numInputs - 1);

	// each row holds the weights of one neuron, indexed by input.
	localparam nnTypesPkg::weightT weightTable [numNeurons][numInputs] = '{
		'{
			1232, -511, 104, 3572, 5892,
			-629, 4495, -632, 5657, 133,
			4400, 1631, 3416, -5262, 2972
		},
		'{
			-2841, 3107, 918, -1466, 2205,
			4731, -390, 1874, -3019, 2660,
			-745, 5120, 388, 1493, -2287
		},
		'{
			4016, -1735, -2504, 667, 3388,
			-918, 2119, 4875, -1240, -3561,
			1907, 286, 5233, -702, 1145
		},
		'{
			-1520, 2748, 3935, -4102, 812,
			1679, -2346, 3053, 497, 4218,
			-1187, -2963, 2431, 3690, -578
		}
	};

	// neurons 1 and 2 share a bias, so an all-zero frame ties them at an output of 3.
	localparam nnTypesPkg::weightT biasTable [numNeurons] = '{
		-692,
		24576,
		24576,
		8192
	};

endpackage

`default_nettype wire

// File: hdl/sampleLoader.sv
`default_nettype none

module sampleLoader (
	input wire clk,
	input wire reset,
	input wire sampleStrobe,
	input wire nnTypesPkg::activationT sampleData,
	output nnTypesPkg::activationT frameWords [nnWeightsPkg::numInputs],
	output logic frameDone
);
	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	logic [countWidth-1:0] wordCount;
	logic lastStrobe;

	assign lastStrobe = sampleStrobe && (wordCount == lastWord);

	// each word lands at the slot given by the count, so the first word of a frame is input 0.
	always_ff @(posedge clk)
	begin
		if (sampleStrobe)
		begin
			frameWords[wordCount] <= sampleData;
		end
	end

	// the count wraps together with the done pulse.
	// A new frame may therefore start on the very next cycle.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wordCount <= '0;
			frameDone <= 1'b0;
		end
		else
		begin
			frameDone <= lastStrobe;
			if (lastStrobe)
			begin
				wordCount <= '0;
			end
			else if (sampleStrobe)
			begin
				wordCount <= wordCount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: project.f
hdl/nnTypesPkg.sv
hdl/nnWeightsPkg.sv
hdl/sampleLoader.sv
hdl/frameBuffer.sv
hdl/denseNeuron.sv
hdl/denseLayer.sv
hdl/nnInferenceTop.sv
verification/nnInferenceTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

logFile=sim.log
simName=nnInferenceSim

verilator --binary --timing --timescale 1ns/1ns \
	--top-module nnInferenceTb -f project.f -o "$simName"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$logFile"; then
	echo "run.sh: simulation passed"
	exit 0
else
	echo "run.sh: simulation failed, see $logFile"
	exit 1
fi

// File: verification/nnInferenceTb.sv
`default_nettype none

module nnInferenceTb;
	timeunit 1ns;
	timeprecision 1ns;

	import nnTypesPkg::*;
	import nnWeightsPkg::*;

	localparam int packedWidth = numNeurons * neuronOutWidth;
	// about 210 cycles of tests, with margin for a stalled pipeline.
	localparam int cycleLimit = 400;
	// last strobe driven, then one edge to sample it and five more to resultValid.
	localparam int resultDelay = 6;

	logic clk;
	logic reset;
	logic sampleStrobe;
	activationT sampleData;
	neuronOutT outputs [numNeurons];
	classIdxT bestClass;
	logic resultValid;

	activationT frame [numInputs];
	int expDue [$];
	logic [packedWidth-1:0] expOutputs [$];
	classIdxT expClass [$];
	logic [packedWidth-1:0] lastOutputs;
	logic [packedWidth-1:0] savedOutputs;
	int cycleCount;
	int mismatchCount;
	int otherErrorCount;
	integer seed;

	nnInferenceTop DUT (
		.clk(clk),
		.reset(reset),
		.sampleStrobe(sampleStrobe),
		.sampleData(sampleData),
		.outputs(outputs),
		.bestClass(bestClass),
		.resultValid(resultValid)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// one neuron with 32-bit wrapping sums, ReLU on bit 31 and bits 28 to 13 kept.
	function automatic neuronOutT modelNeuron(input int n);
		accumT sum;
		sum = biasTable[n];
		for (int i = 0; i < numInputs; i++)
		begin
			sum = sum + frame[i] * weightTable[n][i];
		end
		if (sum[wordWidth-1])
		begin
			return '0;
		end
		return sum[fracBits +: neuronOutWidth];
	endfunction

	task automatic pushExpectation();
		logic [packedWidth-1:0] expected;
		neuronOutT value;
		neuronOutT bestValue;
		classIdxT bestIndex;
		bestValue = '0;
		bestIndex = '0;
		for (int n = 0; n < numNeurons; n++)
		begin
			value = modelNeuron(n);
			expected[n*neuronOutWidth +: neuronOutWidth] = value;
			// the lowest index keeps a tie.
			if (n == 0 || value > bestValue)
			begin
				bestValue = value;
				bestIndex = classIdxT'(n);
			end
		end
		expOutputs.push_back(expected);
		expClass.push_back(bestIndex);
		expDue.push_back(cycleCount + resultDelay);
	endtask

	task automatic checkResult();
		logic [packedWidth-1:0] expected;
		classIdxT expectedClass;
		int due;
		expected = expOutputs.pop_front();
		expectedClass = expClass.pop_front();
		due = expDue.pop_front();
		if (due != cycleCount)
		begin
			$display("resultValid came at cycle %0d instead of cycle %0d", cycleCount, due);
			otherErrorCount++;
		end
		for (int n = 0; n < numNeurons; n++)
		begin
			lastOutputs[n*neuronOutWidth +: neuronOutWidth] = outputs[n];
			if (outputs[n] != expected[n*neuronOutWidth +: neuronOutWidth])
			begin
				$display("mismatch at %0t: outputs[%0d] expected %h actual %h", $time, n,
					expected[n*neuronOutWidth +: neuronOutWidth], outputs[n]);
				mismatchCount++;
			end
		end
		if (bestClass != expectedClass)
		begin
			$display("mismatch at %0t: bestClass expected %0d actual %0d", $time,
				expectedClass, bestClass);
			mismatchCount++;
		end
	endtask

	// outputs are sampled on the falling edge, half a cycle after they change.
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (resultValid)
			begin
				if (expDue.size() == 0)
				begin
					$display("resultValid pulsed at %0t with no frame outstanding", $time);
					otherErrorCount++;
				end
				else
				begin
					checkResult();
				end
			end
			else if (expDue.size() != 0 && cycleCount > expDue[0])
			begin
				$display("resultValid missing for the frame due at cycle %0d", expDue[0]);
				otherErrorCount++;
				void'(expDue.pop_front());
				void'(expOutputs.pop_front());
				void'(expClass.pop_front());
			end
		end
	end

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("errors: %0d mismatches, %0d other failures", mismatchCount,
				otherErrorCount);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic stopStrobes();
		@(negedge clk);
		sampleStrobe = 1'b0;
		sampleData = '0;
	endtask

	task automatic sendFrame(input int gap);
		for (int i = 0; i < numInputs; i++)
		begin
			@(negedge clk);
			sampleStrobe = 1'b1;
			sampleData = frame[i];
			if (i == numInputs - 1)
			begin
				pushExpectation();
			end
			else
			begin
				repeat (gap) stopStrobes();
			end
		end
	endtask

	task automatic awaitResults();
		stopStrobes();
		while (expDue.size() != 0)
		begin
			@(negedge clk);
		end
		// a stray second pulse would show up here.
		repeat (2) @(negedge clk);
	endtask

	task automatic fillFrame(input activationT value);
		for (int i = 0; i < numInputs; i++)
		begin
			frame[i] = value;
		end
	endtask

	task automatic randomizeFrame();
		for (int i = 0; i < numInputs; i++)
		begin
			frame[i] = $random(seed);
		end
	endtask

	task automatic resetStateTest();
		if (resultValid !== 1'b0)
		begin
			$display("resultValid is not low after reset");
			otherErrorCount++;
		end
		for (int n = 0; n < numNeurons; n++)
		begin
			if (outputs[n] !== '0)
			begin
				$display("mismatch at %0t: outputs[%0d] expected 0 actual %h", $time, n,
					outputs[n]);
				mismatchCount++;
			end
		end
		if (bestClass !== '0)
		begin
			$display("mismatch at %0t: bestClass expected 0 actual %0d", $time, bestClass);
			mismatchCount++;
		end
	endtask

	task automatic smallFrameTest();
		fillFrame(32'd1);
		sendFrame(0);
		awaitResults();
	endtask

	// input 13 carries weight -5262 in neuron 0, which pulls its sum far below zero.
	task automatic negativeSumTest();
		fillFrame('0);
		frame[13] = 32'd1000;
		sendFrame(0);
		awaitResults();
		if (outputs[0] != '0)
		begin
			$display("mismatch at %0t: outputs[0] expected 0 actual %h", $time, outputs[0]);
			mismatchCount++;
		end
	endtask

	task automatic backToBackTest();
		repeat (3)
		begin
			randomizeFrame();
			sendFrame(0);
		end
		awaitResults();
	endtask

	task automatic gappedStrobeTest();
		randomizeFrame();
		sendFrame(2);
		awaitResults();
		savedOutputs = lastOutputs;
		sendFrame(0);
		awaitResults();
		if (lastOutputs != savedOutputs)
		begin
			$display("mismatch at %0t: outputs gapped %h ungapped %h", $time, savedOutputs,
				lastOutputs);
			mismatchCount++;
		end
	endtask

	// with no input only the biases count, and neurons 1 and 2 share one.
	task automatic tiedOutputTest();
		fillFrame('0);
		sendFrame(0);
		awaitResults();
	endtask

	initial
	begin
		seed = 32'h11aa7d15;
		cycleCount = 0;
		mismatchCount = 0;
		otherErrorCount = 0;
		reset = 1'b1;
		sampleStrobe = 1'b0;
		sampleData = '0;
		fillFrame('0);
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		resetStateTest();
		smallFrameTest();
		negativeSumTest();
		backToBackTest();
		gappedStrobeTest();
		tiedOutputTest();
		$display("errors: %0d mismatches, %0d other failures", mismatchCount, otherErrorCount);
		if (mismatchCount + otherErrorCount == 0)
		begin
			$display("*** TEST PASSED ***");
		end
		else
		begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
